// File: verilog/logMacPkg.sv
/*
  Shared widths and the power-of-two table for the log-domain MAC engine.
  A log number is {zero, sign, exponent}, with a two's-complement exponent
  of intBits+fracBits bits. Accumulators are sized so no product rounds and
  no sum of up to maxDepth products overflows.
*/
package logMacPkg;

  // exponent fraction bits that feed the linear conversion.
  localparam int tableBits = 4;

  // ############################################################
  // width helpers
  // ############################################################

  function automatic int logBits(input int intBits, input int fracBits);
    return 2 + intBits + fracBits; // zero flag, sign, exponent.
  endfunction

  function automatic int accFracBits(input int intBits);
    return (2 ** intBits) + tableBits; // smallest product stays exact.
  endfunction

  function automatic int accIntBits(input int intBits, input int maxDepth);
    return (2 ** intBits) + 2 + $clog2(maxDepth); // includes the sign.
  endfunction

  function automatic int accBits(input int intBits, input int maxDepth);
    return accIntBits(intBits, maxDepth) + accFracBits(intBits);
  endfunction

  // ############################################################
  // 2^(k/16) scaled by 16, rounded to nearest
  // ############################################################

  localparam logic [4:0] expTable [0:15] = '{
    5'd16,
    5'd17,
    5'd17,
    5'd18,
    5'd19,
    5'd20,
    5'd21,
    5'd22,
    5'd23,
    5'd24,
    5'd25,
    5'd26,
    5'd27,
    5'd28,
    5'd29,
    5'd31
  };

endpackage

// File: verilog/logToLinear.sv
/*
  Converts one log-domain product to a signed fixed-point accumulator value.
  Only the top tableBits exponent fraction bits reach the table, so lower
  fraction bits are truncated. The shift is never negative for any product
  of two valid exponents, so the result is exact in the accumulator.
*/
`timescale 1ns/1ns

module logToLinear #(
  parameter int IntBits  = 3,
  parameter int FracBits = 4,
  parameter int MaxDepth = 16
) (
  input  logic [IntBits+FracBits:0]                          product,
  input  logic                                               productSign,
  input  logic                                               productZero,
  output logic signed [logMacPkg::accBits(IntBits, MaxDepth)-1:0] linear
);

  localparam int AccBits     = logMacPkg::accBits(IntBits, MaxDepth);
  localparam int AccFracBits = logMacPkg::accFracBits(IntBits);
  localparam int ShiftOffset = AccFracBits - logMacPkg::tableBits;

  logic signed [IntBits:0]              intPart;
  logic [logMacPkg::tableBits-1:0]      fracIdx;
  logic [IntBits:0]                     shiftAmt;
  logic [4:0]                           mantissa;
  logic [AccBits-1:0]                   magnitude;

  // floor of the product is its integer field.
  assign intPart = product[IntBits+FracBits:FracBits];
  assign fracIdx = product[FracBits-1 -: logMacPkg::tableBits];

  // n - tableBits + accFracBits, wraps back into range.
  assign shiftAmt = intPart + (IntBits+1)'(ShiftOffset);

  assign mantissa = logMacPkg::expTable[fracIdx];

  always_comb begin
    magnitude = AccBits'(mantissa) << shiftAmt;
    if (productZero) begin
      linear = '0;
    end else if (productSign) begin
      linear = -$signed(magnitude);
    end else begin
      linear = $signed(magnitude);
    end
  end

endmodule

// File: verilog/logPe.sv
/*
  Combinational core of one element: log multiply, convert, accumulate.
  No overflow check; the accumulator width covers MaxDepth products.
*/
`timescale 1ns/1ns

module logPe #(
  parameter int IntBits  = 3,
  parameter int FracBits = 4,
  parameter int MaxDepth = 16
) (
  input  logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  aIn,
  input  logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  bIn,
  input  logic [logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cIn,
  output logic [logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cOut
);

  localparam int LogBits = logMacPkg::logBits(IntBits, FracBits);
  localparam int AccBits = logMacPkg::accBits(IntBits, MaxDepth);
  localparam int ExpBits = IntBits + FracBits;

  logic [ExpBits-1:0] aExp;
  logic [ExpBits-1:0] bExp;
  logic [ExpBits:0]   product;
  logic               productSign;
  logic               productZero;
  logic [AccBits-1:0] linear;

  assign aExp = aIn[ExpBits-1:0];
  assign bExp = bIn[ExpBits-1:0];

  // multiply in the log domain is an exponent add, one bit of growth.
  assign product     = {aExp[ExpBits-1], aExp} + {bExp[ExpBits-1], bExp};
  assign productSign = aIn[LogBits-2] ^ bIn[LogBits-2];
  assign productZero = aIn[LogBits-1] | bIn[LogBits-1];

  logToLinear #(
    .IntBits  (IntBits),
    .FracBits (FracBits),
    .MaxDepth (MaxDepth)
  ) toLinear (
    .product     (product),
    .productSign (productSign),
    .productZero (productZero),
    .linear      (linear)
  );

  assign cOut = cIn + linear; // exact two's-complement sum.

endmodule

// File: verilog/systolicPe.sv
/*
  Registered systolic element. enableMul takes priority over enableShiftOut;
  with both low the element holds. cIn is only loaded on a shift, the
  multiply path accumulates into the element's own register.
*/
`timescale 1ns/1ns

module systolicPe #(
  parameter int IntBits  = 3,
  parameter int FracBits = 4,
  parameter int MaxDepth = 16
) (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic                                              enableMul,
  input  logic                                              enableShiftOut,
  input  logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  aIn,
  input  logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  bIn,
  input  logic [logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cIn,
  output logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  aOut,
  output logic [logMacPkg::logBits(IntBits, FracBits)-1:0]  bOut,
  output logic [logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cOut
);

  localparam int LogBits = logMacPkg::logBits(IntBits, FracBits);
  localparam int AccBits = logMacPkg::accBits(IntBits, MaxDepth);
  localparam logic [LogBits-1:0] ZeroLog = {1'b1, {(LogBits-1){1'b0}}};

  logic [LogBits-1:0] aReg;
  logic [LogBits-1:0] bReg;
  logic [AccBits-1:0] cReg;
  logic [AccBits-1:0] cNext;

  logPe #(
    .IntBits  (IntBits),
    .FracBits (FracBits),
    .MaxDepth (MaxDepth)
  ) core (
    .aIn  (aIn),
    .bIn  (bIn),
    .cIn  (cReg),
    .cOut (cNext)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      aReg <= ZeroLog;
      bReg <= ZeroLog;
      cReg <= '0;
    end else if (enableMul) begin
      aReg <= aIn;
      bReg <= bIn;
      cReg <= cNext;
    end else if (enableShiftOut) begin
      cReg <= cIn; // move one row down.
    end
  end

  assign aOut = aReg;
  assign bOut = bReg;
  assign cOut = cReg;

endmodule

// File: verilog/operandSkew.sv
/*
  Staggers operand lanes: lane i is delayed by exactly i cycles.
  Shifts every cycle regardless of the strobes. Reset loads the
  zero-flag pattern (top bit of a lane set) into every stage.
*/
`timescale 1ns/1ns

module operandSkew #(
  parameter int Lanes    = 4,
  parameter int LaneBits = 9
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [Lanes*LaneBits-1:0] lanesIn,
  output logic [Lanes*LaneBits-1:0] lanesOut
);

  localparam logic [LaneBits-1:0] ZeroLane = {1'b1, {(LaneBits-1){1'b0}}};

  for (genvar i = 0; i < Lanes; i++) begin : gLane
    if (i == 0) begin : gThrough
      assign lanesOut[0 +: LaneBits] = lanesIn[0 +: LaneBits]; // no delay.
    end else begin : gDelay
      logic [LaneBits-1:0] stage [i];

      always_ff @(posedge clock) begin
        if (reset) begin
          for (int j = 0; j < i; j++) begin
            stage[j] <= ZeroLane;
          end
        end else begin
          stage[0] <= lanesIn[i*LaneBits +: LaneBits];
          for (int j = 1; j < i; j++) begin
            stage[j] <= stage[j-1];
          end
        end
      end

      assign lanesOut[i*LaneBits +: LaneBits] = stage[i-1];
    end
  end

endmodule

// File: verilog/systolicArray.sv
/*
  Rows x Cols grid of systolic elements. a moves east, b moves south and
  accumulators shift south on enableShiftOut. Operands leaving the east
  and south edges are dropped; the top row shifts in zero.
*/
`timescale 1ns/1ns

module systolicArray #(
  parameter int Rows     = 4,
  parameter int Cols     = 4,
  parameter int IntBits  = 3,
  parameter int FracBits = 4,
  parameter int MaxDepth = 16
) (
  input  logic                                                   clock,
  input  logic                                                   reset,
  input  logic                                                   enableMul,
  input  logic                                                   enableShiftOut,
  input  logic [Rows*logMacPkg::logBits(IntBits, FracBits)-1:0]  aWest,
  input  logic [Cols*logMacPkg::logBits(IntBits, FracBits)-1:0]  bNorth,
  output logic [Cols*logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cSouth
);

  localparam int LogBits = logMacPkg::logBits(IntBits, FracBits);
  localparam int AccBits = logMacPkg::accBits(IntBits, MaxDepth);

  // ############################################################
  // links between neighbours, index 0 is the array edge
  // ############################################################

  logic [LogBits-1:0] aLink [Rows][Cols+1];
  logic [LogBits-1:0] bLink [Rows+1][Cols];
  logic [AccBits-1:0] cLink [Rows+1][Cols];

  for (genvar r = 0; r < Rows; r++) begin : gWest
    assign aLink[r][0] = aWest[r*LogBits +: LogBits];
  end

  for (genvar c = 0; c < Cols; c++) begin : gEdge
    assign bLink[0][c] = bNorth[c*LogBits +: LogBits];
    assign cLink[0][c] = '0; // nothing above the top row.
    assign cSouth[c*AccBits +: AccBits] = cLink[Rows][c];
  end

  // ############################################################
  // element grid
  // ############################################################

  for (genvar r = 0; r < Rows; r++) begin : gRow
    for (genvar c = 0; c < Cols; c++) begin : gCol
      systolicPe #(
        .IntBits  (IntBits),
        .FracBits (FracBits),
        .MaxDepth (MaxDepth)
      ) pe (
        .clock          (clock),
        .reset          (reset),
        .enableMul      (enableMul),
        .enableShiftOut (enableShiftOut),
        .aIn            (aLink[r][c]),
        .bIn            (bLink[r][c]),
        .cIn            (cLink[r][c]),
        .aOut           (aLink[r][c+1]),
        .bOut           (bLink[r+1][c]),
        .cOut           (cLink[r+1][c])
      );
    end
  end

endmodule

// File: verilog/logMatMulTop.sv
/*
  Log-domain matrix multiply top. Inputs and strobes are registered once,
  then operands are skewed into the array. FracBits must be at least
  logMacPkg::tableBits. Strobes are plain levels, there is no back-pressure.
*/
`timescale 1ns/1ns

module logMatMulTop #(
  parameter int Rows     = 4,
  parameter int Cols     = 4,
  parameter int IntBits  = 3,
  parameter int FracBits = 4,
  parameter int MaxDepth = 16
) (
  input  logic                                                   clock,
  input  logic                                                   reset,
  input  logic [Rows*logMacPkg::logBits(IntBits, FracBits)-1:0]  aIn,
  input  logic [Cols*logMacPkg::logBits(IntBits, FracBits)-1:0]  bIn,
  input  logic                                                   enableMul,
  input  logic                                                   enableShiftOut,
  output logic [Cols*logMacPkg::accBits(IntBits, MaxDepth)-1:0]  cOut
);

  localparam int LogBits = logMacPkg::logBits(IntBits, FracBits);
  localparam logic [LogBits-1:0] ZeroLog = {1'b1, {(LogBits-1){1'b0}}};

  logic [Rows*LogBits-1:0] aReg;
  logic [Cols*LogBits-1:0] bReg;
  logic                    enableMulReg;
  logic                    enableShiftOutReg;
  logic [Rows*LogBits-1:0] aSkewed;
  logic [Cols*LogBits-1:0] bSkewed;

  always_ff @(posedge clock) begin
    if (reset) begin
      aReg              <= {Rows{ZeroLog}};
      bReg              <= {Cols{ZeroLog}};
      enableMulReg      <= 1'b0;
      enableShiftOutReg <= 1'b0;
    end else begin
      aReg              <= aIn;
      bReg              <= bIn;
      enableMulReg      <= enableMul;
      enableShiftOutReg <= enableShiftOut;
    end
  end

  operandSkew #(.Lanes(Rows), .LaneBits(LogBits)) aSkew (
    .clock    (clock),
    .reset    (reset),
    .lanesIn  (aReg),
    .lanesOut (aSkewed)
  );

  operandSkew #(.Lanes(Cols), .LaneBits(LogBits)) bSkew (
    .clock    (clock),
    .reset    (reset),
    .lanesIn  (bReg),
    .lanesOut (bSkewed)
  );

  systolicArray #(
    .Rows     (Rows),
    .Cols     (Cols),
    .IntBits  (IntBits),
    .FracBits (FracBits),
    .MaxDepth (MaxDepth)
  ) array (
    .clock          (clock),
    .reset          (reset),
    .enableMul      (enableMulReg),
    .enableShiftOut (enableShiftOutReg),
    .aWest          (aSkewed),
    .bNorth         (bSkewed),
    .cSouth         (cOut)
  );

endmodule

// File: verification/logMatMulChecks_sva.sv
/*
  Concurrent checks bound into logMatMulTop.
  Relies on the registered strobe names enableMulReg and enableShiftOutReg.
*/
`timescale 1ns/1ns

module logMatMulChecks #(
  parameter int Rows     = 4,
  parameter int Cols     = 4,
  parameter int IntBits  = 3,
  parameter int MaxDepth = 16
) (
  input logic                                                  clock,
  input logic                                                  reset,
  input logic                                                  enableMulReg,
  input logic                                                  enableShiftOutReg,
  input logic [Cols*logMacPkg::accBits(IntBits, MaxDepth)-1:0] cOut
);

  int                        failCount = 0;
  logic [$clog2(Rows+1)-1:0] shiftRun; // shift pulses since the last multiply.

  always_ff @(posedge clock) begin
    if (reset || enableMulReg) begin
      shiftRun <= '0;
    end else if (enableShiftOutReg && shiftRun < Rows) begin
      shiftRun <= shiftRun + 1'b1;
    end
  end

  strobesLowAfterReset: assert property (
    @(posedge clock) reset |=> !enableMulReg && !enableShiftOutReg
  ) else begin
    $error("registered strobes not low in the cycle after reset");
    failCount++;
  end

  holdWhenIdle: assert property (
    @(posedge clock) !reset && !enableMulReg && !enableShiftOutReg |=> $stable(cOut)
  ) else begin
    $error("cOut changed while both registered strobes were low");
    failCount++;
  end

  clearAfterShifts: assert property (
    @(posedge clock) !reset && !enableMulReg && enableShiftOutReg && shiftRun >= Rows - 1
      |=> cOut == '0
  ) else begin
    $error("cOut not zero after a full set of shift pulses");
    failCount++;
  end

endmodule

bind logMatMulTop logMatMulChecks #(
  .Rows     (Rows),
  .Cols     (Cols),
  .IntBits  (IntBits),
  .MaxDepth (MaxDepth)
) checks (
  .clock             (clock),
  .reset             (reset),
  .enableMulReg      (enableMulReg),
  .enableShiftOutReg (enableShiftOutReg),
  .cOut              (cOut)
);

// File: verification/logMatMulTb.sv
/*
  Testbench for logMatMulTop at its default sizes. Operands are random log
  numbers from a fixed seed; results are checked against an exact model.
  Idle operand lanes carry zero-flagged numbers between matrices.
*/
`timescale 1ns/1ns

module logMatMulTb;

  localparam int Rows        = 4;
  localparam int Cols        = 4;
  localparam int IntBits     = 3;
  localparam int FracBits    = 4;
  localparam int MaxDepth    = 16;
  localparam int TableBits   = 4;
  localparam int ExpBits     = IntBits + FracBits;
  localparam int LogBits     = ExpBits + 2;
  localparam int AccFracBits = (2 ** IntBits) + TableBits;
  localparam int AccBits     = (2 ** IntBits) + 2 + $clog2(MaxDepth) + AccFracBits;
  localparam int NumTests    = 58;
  localparam logic [LogBits-1:0] ZeroLog = {1'b1, {(LogBits-1){1'b0}}};

  localparam int KindRandom  = 0;
  localparam int KindExtreme = 1;
  localparam int KindZeroAll = 2;
  localparam int KindZeroA   = 3;
  localparam int KindGaps    = 4;
  localparam int KindReset   = 5;

  logic                    clock;
  logic                    reset;
  logic [Rows*LogBits-1:0] aIn;
  logic [Cols*LogBits-1:0] bIn;
  logic                    enableMul;
  logic                    enableShiftOut;
  logic [Cols*AccBits-1:0] cOut;

  logic [LogBits-1:0] aMat [Rows][MaxDepth];
  logic [LogBits-1:0] bMat [MaxDepth][Cols];
  longint             expC [Rows][Cols];
  int                 expTab [16];
  int                 testKind [NumTests];
  int                 testDepth [NumTests];
  int                 testCount;
  int                 checkCount;
  int                 errorCount;
  int                 cycleCount = 0;
  int                 cycleLimit = 1000000;
  int unsigned        seedValue;

  logMatMulTop #(
    .Rows     (Rows),
    .Cols     (Cols),
    .IntBits  (IntBits),
    .FracBits (FracBits),
    .MaxDepth (MaxDepth)
  ) dut (
    .clock          (clock),
    .reset          (reset),
    .aIn            (aIn),
    .bIn            (bIn),
    .enableMul      (enableMul),
    .enableShiftOut (enableShiftOut),
    .cOut           (cOut)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  // ############################################################
  // reference model
  // ############################################################

  function automatic logic [LogBits-1:0] randLog(input bit extreme);
    logic               zero;
    logic               sign;
    logic [ExpBits-1:0] e;
    zero = ($urandom % 8) == 0;
    sign = 1'($urandom);
    e    = ExpBits'($urandom);
    if (extreme) begin
      zero = 1'b0;
      e = ($urandom % 2) ? {1'b0, {(ExpBits-1){1'b1}}} : {1'b1, {(ExpBits-1){1'b0}}};
    end
    return {zero, sign, e};
  endfunction

  function automatic longint productValue(input logic [LogBits-1:0] a,
                                          input logic [LogBits-1:0] b);
    logic signed [ExpBits-1:0] aExp;
    logic signed [ExpBits-1:0] bExp;
    int                        sum;
    int                        whole;
    int                        frac;
    longint                    mag;
    aExp  = a[ExpBits-1:0];
    bExp  = b[ExpBits-1:0];
    sum   = int'(aExp) + int'(bExp);
    whole = sum >>> FracBits; // floor of the product.
    frac  = (sum >>> (FracBits - TableBits)) & ((2 ** TableBits) - 1);
    mag   = longint'(expTab[frac]) << (whole + AccFracBits - TableBits);
    if (a[LogBits-1] || b[LogBits-1]) begin
      return 0;
    end
    return (a[LogBits-2] ^ b[LogBits-2]) ? -mag : mag;
  endfunction

  task automatic fillMatrices(input int kind, input int depth);
    for (int r = 0; r < Rows; r++) begin
      for (int k = 0; k < depth; k++) begin
        if (kind == KindZeroAll) begin
          aMat[r][k] = ZeroLog;
        end else if (kind == KindZeroA) begin
          aMat[r][k] = randLog(1'b0) | ZeroLog; // flag set, other bits random.
        end else begin
          aMat[r][k] = randLog(kind == KindExtreme);
        end
      end
    end
    for (int k = 0; k < depth; k++) begin
      for (int c = 0; c < Cols; c++) begin
        bMat[k][c] = (kind == KindZeroAll) ? ZeroLog : randLog(kind == KindExtreme);
      end
    end
    for (int r = 0; r < Rows; r++) begin
      for (int c = 0; c < Cols; c++) begin
        expC[r][c] = 0;
        for (int k = 0; k < depth; k++) begin
          expC[r][c] += productValue(aMat[r][k], bMat[k][c]);
        end
      end
    end
  endtask

  // ############################################################
  // drivers and checks
  // ############################################################

  task automatic checkValue(input longint expected, input logic signed [63:0] actual,
                            input int row, input int col);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error %0t: row %0d col %0d expected %0d actual %0d",
               $time, row, col, expected, actual);
    end
  endtask

  task automatic applyReset();
    @(posedge clock);
    reset          <= 1'b1;
    enableMul      <= 1'b1; // strobes stay high through the reset.
    enableShiftOut <= 1'b1;
    repeat (3) @(posedge clock);
    reset          <= 1'b0;
    enableMul      <= 1'b0;
    enableShiftOut <= 1'b0;
  endtask

  task automatic runMul(input int depth);
    logic [Rows*LogBits-1:0] aVec;
    logic [Cols*LogBits-1:0] bVec;
    for (int step = 0; step < depth + Rows + Cols; step++) begin
      for (int r = 0; r < Rows; r++) begin
        if (step < depth) aVec[r*LogBits +: LogBits] = aMat[r][step];
        else aVec[r*LogBits +: LogBits] = ZeroLog; // flush the skew.
      end
      for (int c = 0; c < Cols; c++) begin
        if (step < depth) bVec[c*LogBits +: LogBits] = bMat[step][c];
        else bVec[c*LogBits +: LogBits] = ZeroLog;
      end
      @(posedge clock);
      aIn       <= aVec;
      bIn       <= bVec;
      enableMul <= 1'b1;
    end
    @(posedge clock);
    aIn       <= {Rows{ZeroLog}};
    bIn       <= {Cols{ZeroLog}};
    enableMul <= 1'b0;
    repeat (2) @(posedge clock); // input register, then the last accumulate.
  endtask

  task automatic readOut(input int gap);
    logic signed [AccBits-1:0] lane;
    logic signed [63:0]        wide;
    for (int j = 0; j < Rows; j++) begin
      @(negedge clock);
      for (int c = 0; c < Cols; c++) begin
        lane = cOut[c*AccBits +: AccBits];
        wide = lane;
        checkValue(expC[Rows-1-j][c], wide, Rows - 1 - j, c); // bottom row first.
      end
      @(posedge clock);
      enableShiftOut <= 1'b1;
      @(posedge clock);
      enableShiftOut <= 1'b0;
      @(posedge clock);
      repeat (gap) @(posedge clock);
    end
  endtask

  task automatic addTest(input int kind, input int depth);
    testKind[testCount]  = kind;
    testDepth[testCount] = depth;
    testCount++;
  endtask

  task automatic planTests();
    testCount = 0;
    for (int i = 0; i < 4; i++) addTest(KindExtreme, 1);
    for (int i = 0; i < 24; i++) addTest(KindRandom, 1);
    for (int k = 1; k <= MaxDepth; k++) addTest(KindRandom, k);
    for (int i = 0; i < 8; i++) addTest(KindRandom, 1 + int'($urandom % MaxDepth));
    addTest(KindZeroAll, MaxDepth);
    addTest(KindZeroA, 4);
    addTest(KindGaps, 1 + int'($urandom % MaxDepth));
    addTest(KindGaps, 1 + int'($urandom % MaxDepth));
    addTest(KindReset, 1 + int'($urandom % MaxDepth));
    addTest(KindRandom, 1 + int'($urandom % MaxDepth)); // first matrix after the reset.
  endtask

  task automatic runTest(input int idx);
    int kind;
    int depth;
    kind  = testKind[idx];
    depth = testDepth[idx];
    fillMatrices(kind, depth);
    runMul(depth);
    if (kind == KindGaps) begin
      repeat (6) @(posedge clock);
    end
    if (kind == KindReset) begin
      applyReset();
      for (int r = 0; r < Rows; r++) begin
        for (int c = 0; c < Cols; c++) begin
          expC[r][c] = 0;
        end
      end
    end
    readOut((kind == KindGaps) ? 3 : 0);
  endtask

  // ############################################################
  // main sequence
  // ############################################################

  initial begin
    seedValue      = $urandom(32'h33d3_0fd1);
    checkCount     = 0;
    errorCount     = 0;
    reset          = 1'b1;
    aIn            = {Rows{ZeroLog}};
    bIn            = {Cols{ZeroLog}};
    enableMul      = 1'b0;
    enableShiftOut = 1'b0;
    for (int k = 0; k < 16; k++) begin
      expTab[k] = $rtoi((2.0 ** (real'(k) / 16.0)) * 16.0 + 0.5);
    end
    planTests();
    cycleLimit = 100;
    for (int i = 0; i < testCount; i++) begin
      cycleLimit += testDepth[i] + Rows + Cols + 3 * Rows + 4;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < testCount; i++) begin
      runTest(i);
    end
    @(negedge clock);
    $display("checks %0d, value errors %0d, assertion failures %0d",
             checkCount, errorCount, dut.checks.failCount);
    if (errorCount == 0 && dut.checks.failCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/logMacPkg.sv
verilog/logToLinear.sv
verilog/logPe.sv
verilog/systolicPe.sv
verilog/operandSkew.sv
verilog/systolicArray.sv
verilog/logMatMulTop.sv
verification/logMatMulChecks_sva.sv
verification/logMatMulTb.sv

// File: Makefile
# Verilator build and run for the log-domain matrix multiply testbench.
# Any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= logMatMulTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
# keep running past assertion errors so the testbench prints its summary
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
